//--- rtl/riscv_pkg.sv
// core widths, opcodes, alu operator encoding and pipeline stage structs
`default_nettype none

package riscv_pkg;

  //////////////////////////////////////////////////
  // widths and basic types
  //////////////////////////////////////////////////

  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;

  typedef logic [XLEN-1:0]       word_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  // alu operations, 4 bit encoding
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_SLT  = 4'd5,
    ALU_SLTU = 4'd6,
    ALU_SLL  = 4'd7,
    ALU_SRL  = 4'd8,
    ALU_SRA  = 4'd9
  } alu_op_t;

  //////////////////////////////////////////////////
  // instruction encoding
  //////////////////////////////////////////////////

  // major opcodes kept by this core
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;

  // funct3 for OP and OP-IMM
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // funct3 for branches
  localparam logic [2:0] F3_BEQ = 3'b000;
  localparam logic [2:0] F3_BNE = 3'b001;

  // funct7, alt selects sub and sra
  localparam logic [6:0] F7_ZERO = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;

  // addi x0, x0, 0
  localparam word_t NOP_INSTR = 32'h0000_0013;

  //////////////////////////////////////////////////
  // stage structs
  //////////////////////////////////////////////////

  // id/ex pipeline register contents
  typedef struct packed {
    logic      valid;
    alu_op_t   alu_op;
    word_t     operand_a;
    word_t     operand_b;
    reg_addr_t rd;
    logic      rd_we;
    logic      is_branch;
    logic      branch_ne;
    word_t     branch_a;
    word_t     branch_b;
    word_t     pc;
  } id_ex_t;

  // one register write, also used for forwarding
  typedef struct packed {
    logic      valid;
    reg_addr_t rd;
    word_t     wdata;
  } commit_t;

  // taken branch from EX back to IF and ID
  typedef struct packed {
    logic  taken;
    word_t target;
  } redirect_t;

endpackage

`default_nettype wire

//--- rtl/riscv_register_file.sv
// integer register file with two read ports, one write port and x0 tied to zero
`timescale 1ns/1ps
`default_nettype none

module riscv_register_file import riscv_pkg::*; #(
  parameter int NUM_REGS = 32
) (
  input  logic      clk_i,
  input  logic      reset_i,
  input  reg_addr_t raddr_a_i,
  input  reg_addr_t raddr_b_i,
  output word_t     rdata_a_o,
  output word_t     rdata_b_o,
  input  commit_t   wr_i
);

  word_t mem_q [NUM_REGS];

  // x0 and indices past NUM_REGS read zero
  assign rdata_a_o = (raddr_a_i != '0 && int'(raddr_a_i) < NUM_REGS) ?
                     mem_q[raddr_a_i] : '0;
  assign rdata_b_o = (raddr_b_i != '0 && int'(raddr_b_i) < NUM_REGS) ?
                     mem_q[raddr_b_i] : '0;

  // write port from WB, cleared on reset
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        mem_q[i] <= '0;
      end
    end else if (wr_i.valid && wr_i.rd != '0 && int'(wr_i.rd) < NUM_REGS) begin
      mem_q[wr_i.rd] <= wr_i.wdata;
    end
  end

endmodule

`default_nettype wire

//--- rtl/riscv_if_stage.sv
// fetch stage with program counter, fetch request and if/id instruction register
`timescale 1ns/1ps
`default_nettype none

module riscv_if_stage import riscv_pkg::*; (
  input  logic      clk_i,
  input  logic      reset_i,
  input  logic      fetch_enable_i,
  input  word_t     boot_addr_i,
  input  redirect_t redirect_i,
  output logic      instr_req_o,
  output word_t     instr_addr_o,
  input  word_t     instr_rdata_i,
  output word_t     if_instr_o,
  output word_t     if_pc_o,
  output logic      if_valid_o
);

  logic  fetch_en_q;
  word_t pc_q;
  // address of the fetch whose data returns next
  word_t pend_addr_q;
  logic  pend_valid_q;
  word_t if_instr_q;
  word_t if_pc_q;
  logic  if_valid_q;

  assign instr_req_o  = fetch_en_q;
  // redirect target goes out in the same cycle
  assign instr_addr_o = redirect_i.taken ? redirect_i.target : pc_q;

  // control state
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      fetch_en_q   <= 1'b0;
      pc_q         <= boot_addr_i;
      pend_valid_q <= 1'b0;
      if_valid_q   <= 1'b0;
    end else begin
      fetch_en_q <= fetch_enable_i;
      // next sequential address after each request
      if (fetch_en_q) begin
        pc_q <= instr_addr_o + XLEN'(4);
      end else if (redirect_i.taken) begin
        pc_q <= redirect_i.target;
      end
      pend_valid_q <= fetch_en_q;
      // returning word is wrong path on a redirect
      if_valid_q   <= pend_valid_q & ~redirect_i.taken;
    end
  end

  // payload, nop into ID when nothing valid
  always_ff @(posedge clk_i) begin
    pend_addr_q <= instr_addr_o;
    if_pc_q     <= pend_addr_q;
    if (pend_valid_q && !redirect_i.taken) begin
      if_instr_q <= instr_rdata_i;
    end else begin
      if_instr_q <= NOP_INSTR;
    end
  end

  assign if_instr_o = if_instr_q;
  assign if_pc_o    = if_pc_q;
  assign if_valid_o = if_valid_q;

endmodule

`default_nettype wire

//--- rtl/riscv_id_stage.sv
// decode stage with decoder, immediates, operand forwarding and id/ex register
`timescale 1ns/1ps
`default_nettype none

module riscv_id_stage import riscv_pkg::*; #(
  parameter int NUM_REGS = 32
) (
  input  logic      clk_i,
  input  logic      reset_i,
  input  word_t     if_instr_i,
  input  word_t     if_pc_i,
  input  logic      if_valid_i,
  input  redirect_t redirect_i,
  input  commit_t   ex_fwd_i,
  input  commit_t   wb_commit_i,
  output id_ex_t    id_ex_o
);

  // alu operator from funct3 and the alt bit
  function automatic alu_op_t alu_decode(input logic [2:0] f3, input logic alt);
    alu_op_t op;
    unique case (f3)
      F3_ADD_SUB: op = alt ? ALU_SUB : ALU_ADD;
      F3_SLL:     op = ALU_SLL;
      F3_SLT:     op = ALU_SLT;
      F3_SLTU:    op = ALU_SLTU;
      F3_XOR:     op = ALU_XOR;
      F3_SRL_SRA: op = alt ? ALU_SRA : ALU_SRL;
      F3_OR:      op = ALU_OR;
      default:    op = ALU_AND;
    endcase
    return op;
  endfunction

  // EX result first, then WB, then the array
  function automatic word_t fwd_operand(input reg_addr_t rs, input word_t rf_val,
                                        input commit_t ex, input commit_t wb);
    word_t val;
    val = rf_val;
    if (rs != '0) begin
      if (ex.valid && ex.rd == rs) begin
        val = ex.wdata;
      end else if (wb.valid && wb.rd == rs) begin
        val = wb.wdata;
      end
    end
    return val;
  endfunction

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  reg_addr_t  rs1;
  reg_addr_t  rs2;
  reg_addr_t  rd;
  word_t      imm_i;
  word_t      imm_u;
  word_t      imm_b;
  word_t      rf_a;
  word_t      rf_b;
  word_t      fwd_a;
  word_t      fwd_b;
  logic       legal;
  logic       writes_rd;
  id_ex_t     id_ex_d;
  id_ex_t     id_ex_q;

  //////////////////////////////////////////////////
  // fields and immediates
  //////////////////////////////////////////////////

  assign opcode = if_instr_i[6:0];
  assign rd     = if_instr_i[11:7];
  assign funct3 = if_instr_i[14:12];
  assign rs1    = if_instr_i[19:15];
  assign rs2    = if_instr_i[24:20];
  assign funct7 = if_instr_i[31:25];

  // sign extended i type
  assign imm_i = {{20{if_instr_i[31]}}, if_instr_i[31:20]};
  // upper 20 bits
  assign imm_u = {if_instr_i[31:12], 12'b0};
  // branch offset, bit 0 always zero
  assign imm_b = {{19{if_instr_i[31]}}, if_instr_i[31], if_instr_i[7],
                  if_instr_i[30:25], if_instr_i[11:8], 1'b0};

  //////////////////////////////////////////////////
  // register file and forwarding
  //////////////////////////////////////////////////

  riscv_register_file #(
    .NUM_REGS  ( NUM_REGS    )
  ) registers_i (
    .clk_i     ( clk_i       ),
    .reset_i   ( reset_i     ),
    .raddr_a_i ( rs1         ),
    .raddr_b_i ( rs2         ),
    .rdata_a_o ( rf_a        ),
    .rdata_b_o ( rf_b        ),
    .wr_i      ( wb_commit_i )
  );

  assign fwd_a = fwd_operand(rs1, rf_a, ex_fwd_i, wb_commit_i);
  assign fwd_b = fwd_operand(rs2, rf_b, ex_fwd_i, wb_commit_i);

  //////////////////////////////////////////////////
  // decoder
  //////////////////////////////////////////////////

  always_comb begin
    legal     = 1'b0;
    writes_rd = 1'b0;
    id_ex_d           = '0;
    id_ex_d.alu_op    = ALU_ADD;
    id_ex_d.operand_a = fwd_a;
    id_ex_d.operand_b = fwd_b;
    id_ex_d.rd        = rd;
    id_ex_d.branch_a  = fwd_a;
    id_ex_d.branch_b  = fwd_b;
    id_ex_d.pc        = if_pc_i;
    case (opcode)
      OPC_OP: begin
        // alt funct7 only for sub and sra
        legal = (funct7 == F7_ZERO) ||
                (funct7 == F7_ALT && (funct3 == F3_ADD_SUB || funct3 == F3_SRL_SRA));
        writes_rd      = 1'b1;
        id_ex_d.alu_op = alu_decode(funct3, if_instr_i[30]);
      end
      OPC_OP_IMM: begin
        // shamt encodings need a clean funct7
        if (funct3 == F3_SLL) begin
          legal = (funct7 == F7_ZERO);
        end else if (funct3 == F3_SRL_SRA) begin
          legal = (funct7 == F7_ZERO) || (funct7 == F7_ALT);
        end else begin
          legal = 1'b1;
        end
        writes_rd         = 1'b1;
        // no subi, alt bit only for srai
        id_ex_d.alu_op    = alu_decode(funct3, if_instr_i[30] && funct3 == F3_SRL_SRA);
        id_ex_d.operand_b = imm_i;
      end
      OPC_LUI: begin
        legal             = 1'b1;
        writes_rd         = 1'b1;
        id_ex_d.operand_a = '0;
        id_ex_d.operand_b = imm_u;
      end
      OPC_BRANCH: begin
        legal             = (funct3 == F3_BEQ) || (funct3 == F3_BNE);
        id_ex_d.is_branch = 1'b1;
        id_ex_d.branch_ne = (funct3 == F3_BNE);
        // EX adds this to the pc for the target
        id_ex_d.operand_b = imm_b;
      end
      default: begin
        legal = 1'b0;
      end
    endcase
    // x0 writes are dropped here
    id_ex_d.rd_we = writes_rd && (rd != '0);
    // unsupported or flushed turns into a bubble
    id_ex_d.valid = if_valid_i && legal && !redirect_i.taken;
  end

  // id/ex register, only valid is reset
  always_ff @(posedge clk_i) begin
    id_ex_q <= id_ex_d;
    if (reset_i) begin
      id_ex_q.valid <= 1'b0;
    end
  end

  assign id_ex_o = id_ex_q;

endmodule

`default_nettype wire

//--- rtl/riscv_ex_stage.sv
// execute stage with alu, branch decision and target, and ex/wb commit register
`timescale 1ns/1ps
`default_nettype none

module riscv_ex_stage import riscv_pkg::*; (
  input  logic      clk_i,
  input  logic      reset_i,
  input  id_ex_t    id_ex_i,
  output commit_t   ex_fwd_o,
  output redirect_t redirect_o,
  output commit_t   commit_o
);

  word_t   alu_result;
  logic    [4:0] shamt;
  logic    branch_eq;
  commit_t ex_result;
  commit_t commit_q;

  //////////////////////////////////////////////////
  // alu
  //////////////////////////////////////////////////

  // shifts use the low five bits only
  assign shamt = id_ex_i.operand_b[4:0];

  always_comb begin
    unique case (id_ex_i.alu_op)
      ALU_ADD:  alu_result = id_ex_i.operand_a + id_ex_i.operand_b;
      ALU_SUB:  alu_result = id_ex_i.operand_a - id_ex_i.operand_b;
      ALU_AND:  alu_result = id_ex_i.operand_a & id_ex_i.operand_b;
      ALU_OR:   alu_result = id_ex_i.operand_a | id_ex_i.operand_b;
      ALU_XOR:  alu_result = id_ex_i.operand_a ^ id_ex_i.operand_b;
      // signed compare
      ALU_SLT: begin
        alu_result = word_t'($signed(id_ex_i.operand_a) < $signed(id_ex_i.operand_b));
      end
      ALU_SLTU: alu_result = word_t'(id_ex_i.operand_a < id_ex_i.operand_b);
      ALU_SLL:  alu_result = id_ex_i.operand_a << shamt;
      ALU_SRL:  alu_result = id_ex_i.operand_a >> shamt;
      // arithmetic shift keeps the sign
      ALU_SRA:  alu_result = word_t'($signed(id_ex_i.operand_a) >>> shamt);
      default:  alu_result = '0;
    endcase
  end

  //////////////////////////////////////////////////
  // branch
  //////////////////////////////////////////////////

  assign branch_eq = (id_ex_i.branch_a == id_ex_i.branch_b);

  // beq on equal, bne on not equal
  assign redirect_o.taken  = id_ex_i.valid && id_ex_i.is_branch &&
                             (id_ex_i.branch_ne ? !branch_eq : branch_eq);
  // pc plus the b immediate in operand_b
  assign redirect_o.target = id_ex_i.pc + id_ex_i.operand_b;

  //////////////////////////////////////////////////
  // result and commit
  //////////////////////////////////////////////////

  // branches never set rd_we
  assign ex_result.valid = id_ex_i.valid && id_ex_i.rd_we;
  assign ex_result.rd    = id_ex_i.rd;
  assign ex_result.wdata = alu_result;

  // same result forwarded to ID this cycle
  assign ex_fwd_o = ex_result;

  // ex/wb register, valid cleared on reset
  always_ff @(posedge clk_i) begin
    commit_q <= ex_result;
    if (reset_i) begin
      commit_q.valid <= 1'b0;
    end
  end

  assign commit_o = commit_q;

endmodule

`default_nettype wire

//--- rtl/riscv_core.sv
// top level of the three stage integer core with fetch and commit ports
`timescale 1ns/1ps
`default_nettype none

module riscv_core import riscv_pkg::*; #(
  parameter int NUM_REGS = 32
) (
  input  logic    clk_i,
  input  logic    reset_i,
  input  logic    fetch_enable_i,
  input  word_t   boot_addr_i,
  // instruction fetch, data one cycle after req
  output logic    instr_req_o,
  output word_t   instr_addr_o,
  input  word_t   instr_rdata_i,
  // one entry per register write
  output commit_t commit_o
);

  // if/id
  word_t     if_instr;
  word_t     if_pc;
  logic      if_valid;
  // id/ex
  id_ex_t    id_ex;
  // ex back to id and if
  commit_t   ex_fwd;
  redirect_t redirect;

  //////////////////////////////////////////////////
  // IF stage
  //////////////////////////////////////////////////

  riscv_if_stage if_stage_i (
    .clk_i          ( clk_i          ),
    .reset_i        ( reset_i        ),
    .fetch_enable_i ( fetch_enable_i ),
    .boot_addr_i    ( boot_addr_i    ),
    .redirect_i     ( redirect       ),
    .instr_req_o    ( instr_req_o    ),
    .instr_addr_o   ( instr_addr_o   ),
    .instr_rdata_i  ( instr_rdata_i  ),
    .if_instr_o     ( if_instr       ),
    .if_pc_o        ( if_pc          ),
    .if_valid_o     ( if_valid       )
  );

  //////////////////////////////////////////////////
  // ID stage
  //////////////////////////////////////////////////

  riscv_id_stage #(
    .NUM_REGS    ( NUM_REGS )
  ) id_stage_i (
    .clk_i       ( clk_i    ),
    .reset_i     ( reset_i  ),
    .if_instr_i  ( if_instr ),
    .if_pc_i     ( if_pc    ),
    .if_valid_i  ( if_valid ),
    .redirect_i  ( redirect ),
    .ex_fwd_i    ( ex_fwd   ),
    .wb_commit_i ( commit_o ),
    .id_ex_o     ( id_ex    )
  );

  //////////////////////////////////////////////////
  // EX stage with write back
  //////////////////////////////////////////////////

  riscv_ex_stage ex_stage_i (
    .clk_i      ( clk_i    ),
    .reset_i    ( reset_i  ),
    .id_ex_i    ( id_ex    ),
    .ex_fwd_o   ( ex_fwd   ),
    .redirect_o ( redirect ),
    .commit_o   ( commit_o )
  );

endmodule

`default_nettype wire

//--- dv/riscv_core_checker.sv
// concurrent assertions on fetch, commit and redirect of the bound core
`timescale 1ns/1ps
`default_nettype none

module riscv_core_checker import riscv_pkg::*; (
  input logic      clk_i,
  input logic      reset_i,
  input logic      instr_req_i,
  input word_t     instr_addr_i,
  input commit_t   commit_i,
  input redirect_t redirect_i
);

  logic  taken;
  word_t target;

  assign taken  = redirect_i.taken;
  assign target = redirect_i.target;

  // no fetch during reset or the cycle after
  assert property (@(posedge clk_i) reset_i |=> !instr_req_i)
    else $error("instr_req_o high during or right after reset");

  assert property (@(posedge clk_i) disable iff (reset_i) instr_addr_i[1:0] == 2'b00)
    else $error("instr_addr_o not word aligned");

  // x0 writes never reach the port
  assert property (@(posedge clk_i) disable iff (reset_i) commit_i.valid |-> commit_i.rd != '0)
    else $error("commit_o.rd is zero on a valid commit");

  // fetch restarts at the redirect target
  assert property (@(posedge clk_i) disable iff (reset_i)
    $past(taken, 2) |-> (instr_addr_i - $past(target, 2) <= 32'd8))
    else $error("instr_addr_o too far past the redirect target");

endmodule

bind riscv_core riscv_core_checker checker_i (
  .clk_i        ( clk_i        ),
  .reset_i      ( reset_i      ),
  .instr_req_i  ( instr_req_o  ),
  .instr_addr_i ( instr_addr_o ),
  .commit_i     ( commit_o     ),
  .redirect_i   ( redirect     )
);

`default_nettype wire

//--- dv/tb_riscv_core.sv
// testbench for the core with random program rom, reference model and commit compare
`timescale 1ns/1ps
`default_nettype none

module tb_riscv_core import riscv_pkg::*; ();

  localparam int   PROG_LEN    = 150;
  localparam int   ROM_WORDS   = 256;
  localparam word_t HALT_ADDR  = word_t'(PROG_LEN * 4);
  localparam int   CYCLE_LIMIT = 2000;

  logic    clk_i;
  logic    reset_i;
  logic    fetch_enable_i;
  word_t   boot_addr_i;
  logic    instr_req_o;
  word_t   instr_addr_o;
  word_t   instr_rdata_i;
  commit_t commit_o;

  word_t   rom [ROM_WORDS];
  commit_t exp_q [$];
  int      exp_count;
  int      commit_count;
  int      value_errors;
  int      other_errors;
  logic    timed_out;
  integer  seed;
  // request and address seen by the rom in the middle of the cycle
  logic    fetch_req;
  word_t   fetch_addr;

  riscv_core #(
    .NUM_REGS       ( 32             )
  ) UUT (
    .clk_i          ( clk_i          ),
    .reset_i        ( reset_i        ),
    .fetch_enable_i ( fetch_enable_i ),
    .boot_addr_i    ( boot_addr_i    ),
    .instr_req_o    ( instr_req_o    ),
    .instr_addr_o   ( instr_addr_o   ),
    .instr_rdata_i  ( instr_rdata_i  ),
    .commit_o       ( commit_o       )
  );

  // 40 ns period
  always #20 clk_i = ~clk_i;

  //////////////////////////////////////////////////
  // instruction encoders
  //////////////////////////////////////////////////

  function automatic word_t r_type(input logic alt, input reg_addr_t rs2, input reg_addr_t rs1,
                                   input logic [2:0] f3, input reg_addr_t rd);
    return {alt ? F7_ALT : F7_ZERO, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic word_t i_type(input logic [11:0] imm, input reg_addr_t rs1,
                                   input logic [2:0] f3, input reg_addr_t rd);
    return {imm, rs1, f3, rd, OPC_OP_IMM};
  endfunction

  function automatic word_t lui_word(input logic [19:0] imm, input reg_addr_t rd);
    return {imm, rd, OPC_LUI};
  endfunction

  // offset in bytes and ne selects bne
  function automatic word_t branch_word(input int offset, input reg_addr_t rs2,
                                        input reg_addr_t rs1, input logic ne);
    logic [12:0] b;
    b = 13'(offset);
    return {b[12], b[10:5], rs2, rs1, 2'b00, ne, b[4:1], b[11], OPC_BRANCH};
  endfunction

  //////////////////////////////////////////////////
  // random program
  //////////////////////////////////////////////////

  task automatic build_program();
    int          k;
    int          kind;
    int          off;
    reg_addr_t   rd;
    reg_addr_t   rs1;
    reg_addr_t   rs2;
    logic [2:0]  f3;
    logic        alt;
    logic [11:0] imm;
    // illegal opcode with the index in the upper bits
    for (k = 0; k < ROM_WORDS; k++) begin
      rom[k] = {k[24:0], 7'h7f};
    end
    for (k = 0; k < PROG_LEN; k++) begin
      kind = $unsigned($random(seed)) % 16;
      rd   = reg_addr_t'($random(seed) & 7);
      rs1  = reg_addr_t'($random(seed) & 7);
      rs2  = reg_addr_t'($random(seed) & 7);
      f3   = 3'($random(seed));
      alt  = (f3 == 3'd0 || f3 == 3'd5) && (($random(seed) & 1) != 0);
      if (kind < 2) begin
        // forward only and never past the halt loop
        off = 1 + $unsigned($random(seed)) % 6;
        if (k + off > PROG_LEN) begin
          off = PROG_LEN - k;
        end
        rom[k] = branch_word(off * 4, rs2, rs1, f3[0]);
      end else if (kind < 4) begin
        rom[k] = lui_word(20'($random(seed)), rd);
      end else if (kind < 10) begin
        rom[k] = r_type(alt, rs2, rs1, f3, rd);
      end else begin
        if (f3 == 3'd1) begin
          imm = {7'b0, rs2};
        end else if (f3 == 3'd5) begin
          imm = {alt ? 7'b0100000 : 7'b0, 5'($random(seed))};
        end else begin
          imm = 12'($random(seed));
        end
        rom[k] = i_type(imm, rs1, f3, rd);
      end
    end
    // beq x0, x0, 0
    rom[PROG_LEN] = branch_word(0, '0, '0, 1'b0);
  endtask

  //////////////////////////////////////////////////
  // reference isa model
  //////////////////////////////////////////////////

  function automatic word_t alu_ref(input logic [2:0] f3, input logic alt,
                                    input word_t a, input word_t b);
    case (f3)
      3'd0:    return alt ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3:    return (a < b) ? 32'd1 : 32'd0;
      3'd4:    return a ^ b;
      3'd5:    return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic void reference_run();
    word_t     regs [32];
    word_t     pc;
    word_t     pc_next;
    word_t     instr;
    word_t     a;
    word_t     b;
    word_t     res;
    logic      wr;
    reg_addr_t rd;
    int        steps;
    commit_t   c;
    for (int i = 0; i < 32; i++) begin
      regs[i] = '0;
    end
    pc = '0;
    steps = 0;
    exp_q.delete();
    while (pc != HALT_ADDR && steps < CYCLE_LIMIT) begin
      instr   = rom[pc[9:2]];
      rd      = instr[11:7];
      a       = regs[instr[19:15]];
      b       = regs[instr[24:20]];
      pc_next = pc + 32'd4;
      wr      = 1'b1;
      res     = '0;
      case (instr[6:0])
        OPC_OP:     res = alu_ref(instr[14:12], instr[30], a, b);
        OPC_OP_IMM: begin
          // only srai uses the alt bit
          res = alu_ref(instr[14:12], instr[30] && instr[14:12] == 3'd5, a,
                        {{20{instr[31]}}, instr[31:20]});
        end
        OPC_LUI:    res = {instr[31:12], 12'h000};
        OPC_BRANCH: begin
          wr = 1'b0;
          // beq on equal and bne otherwise
          if ((a == b) ^ instr[12]) begin
            pc_next = pc + {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                            instr[11:8], 1'b0};
          end
        end
        default:    wr = 1'b0;
      endcase
      if (wr && rd != '0) begin
        regs[rd] = res;
        c.valid  = 1'b1;
        c.rd     = rd;
        c.wdata  = res;
        exp_q.push_back(c);
      end
      pc = pc_next;
      steps++;
    end
    exp_count = exp_q.size();
  endfunction

  //////////////////////////////////////////////////
  // compare tasks
  //////////////////////////////////////////////////

  task automatic check_commit(input commit_t expected, input commit_t observed);
    if (observed.rd !== expected.rd) begin
      value_errors++;
      $display("error at %0t: commit_o.rd expected %0d observed %0d",
               $time, expected.rd, observed.rd);
    end
    if (observed.wdata !== expected.wdata) begin
      value_errors++;
      $display("error at %0t: commit_o.wdata expected %08h observed %08h",
               $time, expected.wdata, observed.wdata);
    end
  endtask

  task automatic check_addr(input word_t expected, input word_t observed);
    if (observed !== expected) begin
      value_errors++;
      $display("error at %0t: instr_addr_o expected %08h observed %08h",
               $time, expected, observed);
    end
  endtask

  // rom data only follows a request and holds otherwise
  always @(negedge clk_i) begin
    fetch_req  = instr_req_o;
    fetch_addr = instr_addr_o;
  end

  always @(posedge clk_i) begin
    #2;
    if (fetch_req === 1'b1) begin
      instr_rdata_i = rom[fetch_addr[9:2]];
    end
  end

  // every commit against the head of the model queue
  always @(negedge clk_i) begin : compare_commits
    commit_t expected;
    if (!reset_i && commit_o.valid === 1'b1) begin
      if (exp_q.size() == 0) begin
        other_errors++;
        $display("unexpected commit at %0t after the last expected one", $time);
      end else begin
        expected = exp_q.pop_front();
        check_commit(expected, commit_o);
      end
      commit_count++;
    end
  end

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////

  initial begin
    int cycles;
    seed           = 32'h7e1a_cff0;
    clk_i          = 1'b0;
    reset_i        = 1'b1;
    fetch_enable_i = 1'b0;
    boot_addr_i    = '0;
    instr_rdata_i  = NOP_INSTR;
    commit_count   = 0;
    value_errors   = 0;
    other_errors   = 0;
    timed_out      = 1'b0;
    build_program();
    reference_run();
    repeat (10) @(posedge clk_i);
    #2;
    reset_i        = 1'b0;
    fetch_enable_i = 1'b1;
    // run until the model's commit count
    cycles = 0;
    while (commit_count < exp_count && cycles < CYCLE_LIMIT) begin
      @(posedge clk_i);
      cycles++;
    end
    if (commit_count < exp_count) begin
      timed_out = 1'b1;
      $display("timeout: the core did not reach the halt loop in time");
    end else begin
      // sync to the loop head
      cycles = 0;
      @(negedge clk_i);
      while (instr_addr_o != HALT_ADDR && cycles < 10) begin
        @(negedge clk_i);
        cycles++;
      end
      if (instr_addr_o != HALT_ADDR) begin
        timed_out = 1'b1;
        $display("timeout: the core did not reach the halt loop in time");
      end else begin
        // loop runs through halt, +4 and +8 then back
        for (int i = 0; i < 9; i++) begin
          check_addr(HALT_ADDR + word_t'(4 * (i % 3)), instr_addr_o);
          @(negedge clk_i);
        end
      end
    end
    if (commit_count != exp_count) begin
      other_errors++;
      $display("commit count differs from the reference model");
    end
    $display("value errors: %0d, other errors: %0d, commits: %0d of %0d",
             value_errors, other_errors, commit_count, exp_count);
    if (value_errors == 0 && other_errors == 0 && !timed_out) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
rtl/riscv_pkg.sv
rtl/riscv_register_file.sv
rtl/riscv_if_stage.sv
rtl/riscv_id_stage.sv
rtl/riscv_ex_stage.sv
rtl/riscv_core.sv
dv/riscv_core_checker.sv
dv/tb_riscv_core.sv

//--- run_verilator.sh
#!/bin/sh
# build and run the core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_riscv_core -f vlog.f

./obj_dir/Vtb_riscv_core > sim.log 2>&1
cat sim.log

if grep -qx "Test OK" sim.log; then
  exit 0
fi
exit 1
